// ==== dv/lsu_assert.sv ====
`timescale 1ns/1ps

module lsu_assert (
	input logic               clk,
	input logic               rst_n_i,
	input logic               rsp_valid_i,
	input logic               rsp_ready_i,
	input lsu_pkg::lsu_rsp_t  rsp_i,
	input logic               ram_we_i,
	input lsu_pkg::lsu_req_t  req_i
);

	logic store_ok;

	// Aligned stores of the in-flight request
	assign store_ok = (req_i.aluop == lsu_pkg::OP_SB) ||
	                  ((req_i.aluop == lsu_pkg::OP_SH) && !req_i.addr[0]) ||
	                  ((req_i.aluop == lsu_pkg::OP_SW) && (req_i.addr[1:0] == 2'b00));

	// Stalled response keeps its payload
	a_rsp_stable: assert property (
		@(posedge clk) disable iff (!rst_n_i)
		(rsp_valid_i && !rsp_ready_i) |=> (rsp_valid_i && $stable(rsp_i))
	) else $error("response payload changed while stalled");

	// Faulting accesses never reach the RAM
	a_no_fault_write: assert property (
		@(posedge clk) disable iff (!rst_n_i)
		ram_we_i |-> store_ok
	) else $error("RAM write for a load, a NOP or a misaligned store");

	a_idle_after_reset: assert property (
		@(posedge clk) !rst_n_i |=> !rsp_valid_i
	) else $error("response valid right after reset");

endmodule

// ==== dv/lsu_tb.sv ====
`timescale 1ns/1ps

module lsu_tb;

	localparam int WAIT_LIMIT = 2000;

	logic               clk;
	logic               rst_n_i;
	logic               req_valid_i;
	logic               req_ready_o;
	lsu_pkg::aluop_t    req_aluop_i;
	logic [31:0]        req_addr_i;
	logic [31:0]        req_reg2_i;
	logic [4:0]         req_wd_i;
	logic [31:0]        req_epc_i;
	logic               rsp_valid_o;
	logic               rsp_ready_i;
	logic [4:0]         rsp_wd_o;
	logic               rsp_wreg_o;
	logic [31:0]        rsp_wdata_o;
	lsu_pkg::exc_code_t rsp_exc_code_o;
	logic [31:0]        rsp_epc_o;
	logic [31:0]        rsp_badvaddr_o;

	// Shadow copy of the data RAM, indexed like the DUT
	logic [31:0]       shadow [lsu_pkg::RAM_WORDS];
	lsu_pkg::lsu_rsp_t exp_q [$];
	int                errors = 0;
	int                sent = 0;
	int                received = 0;
	int                tests = 0;
	int                err_mark = 0;
	int                sent_mark = 0;
	bit                hung = 1'b0;
	bit                stall_en = 1'b0;

	lsu_top lsu_top_i (.*);

	bind lsu_top lsu_assert lsu_assert_i (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.rsp_valid_i(rsp_valid_o),
		.rsp_ready_i(rsp_ready_i),
		.rsp_i      (rsp_out),
		.ram_we_i   (ram_we),
		.req_i      (cur_req)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Response sink, stalls at random during the mixed run
	initial begin
		rsp_ready_i = 1'b0;
		forever begin
			@(negedge clk);
			if (stall_en) begin
				rsp_ready_i = 1'($urandom % 2);
			end else begin
				rsp_ready_i = 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Compare tasks and reference model
	//////////////////////////////////////////////////////////////////////

	task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] want);
		if (got !== want) begin
			$display("Error at %0t: %s = %h, expected %h", $time, name, got, want);
			errors++;
		end
	endtask

	task automatic check_exc(input string name, input lsu_pkg::exc_code_t got,
	                         input lsu_pkg::exc_code_t want);
		if (got !== want) begin
			$display("Error at %0t: %s = %h, expected %h", $time, name, got, want);
			errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic want);
		if (got !== want) begin
			$display("Error at %0t: %s = %b, expected %b", $time, name, got, want);
			errors++;
		end
	endtask

	function automatic lsu_pkg::lsu_rsp_t expected_rsp(input lsu_pkg::lsu_req_t req);
		lsu_pkg::lsu_rsp_t rsp;
		logic [7:0]        idx;
		logic [4:0]        sh;
		logic [31:0]       word;
		logic [31:0]       lane;
		logic [31:0]       mask;
		logic              is_load;
		logic              is_store;
		logic              bad;
		idx  = req.addr[9:2];
		sh   = {req.addr[1:0], 3'b000};
		word = shadow[idx];
		lane = word >> sh;
		mask = 32'h0;
		rsp  = '0;
		rsp.wd = req.wd;
		case (req.aluop)
			lsu_pkg::OP_LB:  rsp.wdata = {{24{lane[7]}}, lane[7:0]};
			lsu_pkg::OP_LBU: rsp.wdata = {24'h0, lane[7:0]};
			lsu_pkg::OP_LH:  rsp.wdata = {{16{lane[15]}}, lane[15:0]};
			lsu_pkg::OP_LHU: rsp.wdata = {16'h0, lane[15:0]};
			lsu_pkg::OP_LW:  rsp.wdata = word;
			lsu_pkg::OP_SB:  mask = 32'h0000_00ff;
			lsu_pkg::OP_SH:  mask = 32'h0000_ffff;
			lsu_pkg::OP_SW:  mask = 32'hffff_ffff;
			default: ;
		endcase
		is_load  = (req.aluop inside {lsu_pkg::OP_LB, lsu_pkg::OP_LBU, lsu_pkg::OP_LH,
		                              lsu_pkg::OP_LHU, lsu_pkg::OP_LW});
		is_store = (mask != 32'h0);
		// Halfwords need bit 0 clear, words both low bits
		bad = ((req.aluop inside {lsu_pkg::OP_LH, lsu_pkg::OP_LHU, lsu_pkg::OP_SH}) &&
		       req.addr[0]) ||
		      ((req.aluop inside {lsu_pkg::OP_LW, lsu_pkg::OP_SW}) && (req.addr[1:0] != 2'b00));
		if (bad) begin
			rsp.exc_code = is_load ? lsu_pkg::EC_ADEL : lsu_pkg::EC_ADES;
			rsp.epc      = req.epc;
			rsp.badvaddr = req.addr;
			rsp.wdata    = 32'h0;
		end else begin
			rsp.wreg = is_load;
			if (is_store) begin
				shadow[idx] = (word & ~(mask << sh)) | ((req.reg2 & mask) << sh);
			end
		end
		return rsp;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Driver helpers
	//////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] word_addr(input int idx);
		logic [31:0] r;
		r = $urandom;
		// High bits fall outside the RAM index
		return {r[31:10], idx[7:0], 2'b00};
	endfunction

	function automatic lsu_pkg::aluop_t random_op();
		case ($urandom % 10)
			0: return lsu_pkg::OP_LB;
			1: return lsu_pkg::OP_LBU;
			2: return lsu_pkg::OP_LH;
			3: return lsu_pkg::OP_LHU;
			4: return lsu_pkg::OP_LW;
			5: return lsu_pkg::OP_SB;
			6: return lsu_pkg::OP_SH;
			7: return lsu_pkg::OP_SW;
			8: return lsu_pkg::OP_NOP;
			default: return 8'($urandom);
		endcase
	endfunction

	task automatic send(input lsu_pkg::aluop_t op, input logic [31:0] addr,
	                    input logic [31:0] data);
		lsu_pkg::lsu_req_t req;
		int                n;
		if (!hung) begin
			req.aluop = op;
			req.addr  = addr;
			req.reg2  = data;
			req.wd    = 5'($urandom);
			req.epc   = $urandom;
			@(negedge clk);
			req_valid_i = 1'b1;
			req_aluop_i = req.aluop;
			req_addr_i  = req.addr;
			req_reg2_i  = req.reg2;
			req_wd_i    = req.wd;
			req_epc_i   = req.epc;
			n = 0;
			do begin
				@(posedge clk);
				n++;
			end while (!req_ready_o && n < WAIT_LIMIT);
			if (req_ready_o) begin
				exp_q.push_back(expected_rsp(req));
				sent++;
			end else begin
				$display("Timeout: request not accepted within %0d cycles", WAIT_LIMIT);
				hung = 1'b1;
			end
		end
	endtask

	task automatic drain();
		int n;
		@(negedge clk);
		req_valid_i = 1'b0;
		n = 0;
		while (!hung && exp_q.size() != 0) begin
			@(posedge clk);
			n++;
			if (n >= WAIT_LIMIT) begin
				$display("Timeout: %0d responses never arrived", exp_q.size());
				hung = 1'b1;
			end
		end
		// Idle gap where a surplus response would show up
		repeat (8) @(posedge clk);
	endtask

	task automatic end_test(input string name);
		tests++;
		$display("%-12s %4d requests, %0d errors", name, sent - sent_mark, errors - err_mark);
		sent_mark = sent;
		err_mark  = errors;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Compare process
	//////////////////////////////////////////////////////////////////////

	initial begin
		lsu_pkg::lsu_rsp_t want;
		forever begin
			@(posedge clk);
			if (rst_n_i === 1'b1 && rsp_valid_o === 1'b1 && rsp_ready_i === 1'b1) begin
				received++;
				if (exp_q.size() == 0) begin
					$display("Unexpected response at %0t with no request outstanding", $time);
					errors++;
				end else begin
					want = exp_q.pop_front();
					check_word("rsp_wd_o", {27'h0, rsp_wd_o}, {27'h0, want.wd});
					check_bit("rsp_wreg_o", rsp_wreg_o, want.wreg);
					check_word("rsp_wdata_o", rsp_wdata_o, want.wdata);
					check_exc("rsp_exc_code_o", rsp_exc_code_o, want.exc_code);
					check_word("rsp_epc_o", rsp_epc_o, want.epc);
					check_word("rsp_badvaddr_o", rsp_badvaddr_o, want.badvaddr);
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		int              i;
		int              w;
		int              lane;
		logic [31:0]     base;
		logic [31:0]     addr;
		logic [7:0]      b;
		logic [15:0]     h;
		lsu_pkg::aluop_t op;
		void'($urandom(89));
		rst_n_i     = 1'b0;
		req_valid_i = 1'b0;
		req_aluop_i = lsu_pkg::OP_NOP;
		req_addr_i  = 32'h0;
		req_reg2_i  = 32'h0;
		req_wd_i    = 5'h0;
		req_epc_i   = 32'h0;

		for (i = 0; i < 16; i++) begin
			@(negedge clk);
			check_bit("rsp_valid_o", rsp_valid_o, 1'b0);
		end
		rst_n_i = 1'b1;
		send(lsu_pkg::OP_NOP, 32'h0000_0040, 32'hdead_beef);
		drain();
		end_test("reset_nop");

		// Fills every word, later tests rely on known contents
		for (i = 0; i < lsu_pkg::RAM_WORDS; i++) begin
			send(lsu_pkg::OP_SW, word_addr(i), $urandom);
		end
		for (i = 0; i < lsu_pkg::RAM_WORDS; i++) begin
			send(lsu_pkg::OP_LW, word_addr(i), $urandom);
		end
		drain();
		end_test("word_rw");

		for (w = 0; w < 2; w++) begin
			base = word_addr(10 + w);
			for (lane = 0; lane < 4; lane++) begin
				b    = 8'($urandom);
				b[7] = lane[0] ^ w[0];
				send(lsu_pkg::OP_SB, base + lane, {24'($urandom), b});
			end
			for (lane = 0; lane < 4; lane++) begin
				send(lsu_pkg::OP_LB, base + lane, 32'h0);
				send(lsu_pkg::OP_LBU, base + lane, 32'h0);
			end
		end
		drain();
		end_test("byte_rw");

		for (w = 0; w < 2; w++) begin
			base     = word_addr(20 + w);
			h        = 16'($urandom);
			h[15]    = w[0];
			send(lsu_pkg::OP_SH, base, {16'($urandom), h});
			h        = 16'($urandom);
			h[15]    = ~w[0];
			send(lsu_pkg::OP_SH, base + 2, {16'($urandom), h});
			for (lane = 0; lane < 4; lane += 2) begin
				send(lsu_pkg::OP_LH, base + lane, 32'h0);
				send(lsu_pkg::OP_LHU, base + lane, 32'h0);
			end
		end
		drain();
		end_test("half_rw");

		base = word_addr(30);
		send(lsu_pkg::OP_SW, base, $urandom);
		for (lane = 1; lane < 4; lane++) begin
			send(lsu_pkg::OP_LW, base + lane, 32'h0);
			send(lsu_pkg::OP_SW, base + lane, $urandom);
			if (lane != 2) begin
				send(lsu_pkg::OP_LH, base + lane, 32'h0);
				send(lsu_pkg::OP_LHU, base + lane, 32'h0);
				send(lsu_pkg::OP_SH, base + lane, $urandom);
			end
		end
		send(lsu_pkg::OP_LW, base, 32'h0);
		drain();
		end_test("align_fault");

		stall_en = 1'b1;
		for (i = 0; i < 200; i++) begin
			op   = random_op();
			addr = $urandom;
			// Mostly aligned so the RAM sees real traffic
			if (($urandom % 4) != 0) begin
				addr[0] = 1'b0;
				if (op == lsu_pkg::OP_LW || op == lsu_pkg::OP_SW) begin
					addr[1] = 1'b0;
				end
			end
			send(op, addr, $urandom);
		end
		drain();
		stall_en = 1'b0;
		end_test("random_mix");

		check_word("response count", received, sent);
		$display("Summary: %0d tests, %0d requests, %0d responses, %0d errors",
		         tests, sent, received, errors);
		if (errors == 0 && !hung) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// ==== filelist.f ====
hdl/lsu_pkg.sv
hdl/lsu_fifo.sv
hdl/mem_align.sv
hdl/data_ram.sv
hdl/lsu_ctrl.sv
hdl/lsu_top.sv
dv/lsu_assert.sv
dv/lsu_tb.sv

// ==== hdl/data_ram.sv ====
`timescale 1ns/1ps

module data_ram (
	input  logic                       clk,
	input  logic                       ce_i,
	input  logic                       we_i,
	input  logic [3:0]                 sel_i,
	input  logic [lsu_pkg::RAM_AW-1:0] addr_i,
	input  logic [31:0]                wdata_i,
	output logic [31:0]                rdata_o
);

	logic [31:0] mem [lsu_pkg::RAM_WORDS];

	// Read returns the old word on a same-cycle write
	always_ff @(posedge clk) begin
		if (ce_i) begin
			if (we_i) begin
				for (int i = 0; i < 4; i++) begin
					if (sel_i[i]) begin
						mem[addr_i][8*i +: 8] <= wdata_i[8*i +: 8];
					end
				end
			end
			rdata_o <= mem[addr_i];
		end
	end

endmodule

// ==== hdl/lsu_ctrl.sv ====
`timescale 1ns/1ps

module lsu_ctrl (
	input  logic               clk,
	input  logic               rst_n_i,
	input  logic               req_valid_i,
	output logic               req_pop_o,
	input  logic               rsp_ready_i,
	output logic               rsp_push_o,
	input  logic               store_i,
	input  lsu_pkg::exc_code_t exc_code_i,
	output logic               ram_ce_o,
	output logic               ram_we_o,
	output logic               hold_o
);

	typedef enum logic {
		S_ISSUE,
		S_COMPLETE
	} state_t;

	state_t state_q;
	logic   issue;

	//////////////////////////////////////////////////////////////////////
	// Two-cycle access sequence
	//////////////////////////////////////////////////////////////////////

	// Room in the response FIFO now means room at completion,
	// nothing else pushes in between
	assign issue = (state_q == S_ISSUE) && req_valid_i && rsp_ready_i;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			state_q <= S_ISSUE;
		end else begin
			case (state_q)
				S_ISSUE: begin
					if (issue) begin
						state_q <= S_COMPLETE;
					end
				end
				default: begin
					state_q <= S_ISSUE;
				end
			endcase
		end
	end

	// Pop and capture the head while the RAM reads it
	assign req_pop_o = issue;
	assign hold_o    = issue;

	// Completion writes back merged data and hands off the response
	assign rsp_push_o = (state_q == S_COMPLETE);
	assign ram_we_o   = (state_q == S_COMPLETE) && store_i &&
	                    (exc_code_i == lsu_pkg::EC_NONE);
	assign ram_ce_o   = issue || ram_we_o;

endmodule

// ==== hdl/lsu_fifo.sv ====
`timescale 1ns/1ps

module lsu_fifo #(
	parameter type payload_t = logic [31:0]
) (
	input  logic     clk,
	input  logic     rst_n_i,
	input  logic     push_valid_i,
	input  payload_t push_data_i,
	output logic     push_ready_o,
	output logic     pop_valid_o,
	output payload_t pop_data_o,
	input  logic     pop_ready_i
);

	payload_t   mem [2];
	logic       wr_ptr_q;
	logic       rd_ptr_q;
	logic [1:0] count_q;
	logic       live_q;
	logic       do_push;
	logic       do_pop;

	// Stays closed until the first cycle out of reset
	assign push_ready_o = live_q && ((count_q != 2'd2) || pop_ready_i);
	assign pop_valid_o  = (count_q != 2'd0);
	assign pop_data_o   = mem[rd_ptr_q];

	assign do_push = push_valid_i && push_ready_o;
	assign do_pop  = pop_valid_o && pop_ready_i;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			wr_ptr_q <= 1'b0;
			rd_ptr_q <= 1'b0;
			count_q  <= 2'd0;
			live_q   <= 1'b0;
		end else begin
			live_q <= 1'b1;
			if (do_push) begin
				wr_ptr_q <= ~wr_ptr_q;
			end
			if (do_pop) begin
				rd_ptr_q <= ~rd_ptr_q;
			end
			count_q <= count_q + {1'b0, do_push} - {1'b0, do_pop};
		end
	end

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr_q] <= push_data_i;
		end
	end

endmodule

// ==== hdl/lsu_pkg.sv ====
package lsu_pkg;

	//////////////////////////////////////////////////////////////////////
	// Operation codes
	//////////////////////////////////////////////////////////////////////

	typedef logic [7:0] aluop_t;

	localparam aluop_t OP_NOP = 8'b0000_0000;
	localparam aluop_t OP_LB  = 8'b1110_0000;
	localparam aluop_t OP_LBU = 8'b1110_0100;
	localparam aluop_t OP_LH  = 8'b1110_0001;
	localparam aluop_t OP_LHU = 8'b1110_0101;
	localparam aluop_t OP_LW  = 8'b1110_0011;
	localparam aluop_t OP_SB  = 8'b1110_1000;
	localparam aluop_t OP_SH  = 8'b1110_1001;
	localparam aluop_t OP_SW  = 8'b1110_1011;

	// MIPS cause codes
	typedef logic [4:0] exc_code_t;

	localparam exc_code_t EC_NONE = 5'h00;
	localparam exc_code_t EC_ADEL = 5'h04;
	localparam exc_code_t EC_ADES = 5'h05;

	// Data RAM, indexed by address bits RAM_AW+1 down to 2
	localparam int RAM_WORDS = 256;
	localparam int RAM_AW    = 8;

	//////////////////////////////////////////////////////////////////////
	// Payloads
	//////////////////////////////////////////////////////////////////////

	typedef struct packed {
		aluop_t      aluop;
		logic [31:0] addr;
		logic [31:0] reg2;
		logic [4:0]  wd;
		logic [31:0] epc;
	} lsu_req_t;

	typedef struct packed {
		logic [4:0]  wd;
		logic        wreg;
		logic [31:0] wdata;
		exc_code_t   exc_code;
		logic [31:0] epc;
		logic [31:0] badvaddr;
	} lsu_rsp_t;

endpackage

// ==== hdl/lsu_top.sv ====
`timescale 1ns/1ps

module lsu_top (
	input  logic               clk,
	input  logic               rst_n_i,
	input  logic               req_valid_i,
	output logic               req_ready_o,
	input  lsu_pkg::aluop_t    req_aluop_i,
	input  logic [31:0]        req_addr_i,
	input  logic [31:0]        req_reg2_i,
	input  logic [4:0]         req_wd_i,
	input  logic [31:0]        req_epc_i,
	output logic               rsp_valid_o,
	input  logic               rsp_ready_i,
	output logic [4:0]         rsp_wd_o,
	output logic               rsp_wreg_o,
	output logic [31:0]        rsp_wdata_o,
	output lsu_pkg::exc_code_t rsp_exc_code_o,
	output logic [31:0]        rsp_epc_o,
	output logic [31:0]        rsp_badvaddr_o
);

	lsu_pkg::lsu_req_t           req_in;
	lsu_pkg::lsu_req_t           req_head;
	lsu_pkg::lsu_req_t           cur_req;
	lsu_pkg::lsu_rsp_t           rsp_new;
	lsu_pkg::lsu_rsp_t           rsp_out;
	logic                        req_avail;
	logic                        req_pop;
	logic                        rsp_room;
	logic                        rsp_push;
	logic                        store;
	logic                        hold;
	logic                        ram_ce;
	logic                        ram_we;
	logic [3:0]                  ram_sel;
	logic [lsu_pkg::RAM_AW-1:0]  ram_addr;
	logic [31:0]                 ram_wdata;
	logic [31:0]                 ram_rdata;

	assign req_in.aluop = req_aluop_i;
	assign req_in.addr  = req_addr_i;
	assign req_in.reg2  = req_reg2_i;
	assign req_in.wd    = req_wd_i;
	assign req_in.epc   = req_epc_i;

	lsu_fifo #(.payload_t(lsu_pkg::lsu_req_t)) req_fifo_i (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.push_valid_i(req_valid_i),
		.push_data_i (req_in),
		.push_ready_o(req_ready_o),
		.pop_valid_o (req_avail),
		.pop_data_o  (req_head),
		.pop_ready_i (req_pop)
	);

	// In-flight request, seen by the aligner in the complete cycle
	always_ff @(posedge clk) begin
		if (hold) begin
			cur_req <= req_head;
		end
	end

	// Issue reads at the FIFO head, completion writes at the held address
	assign ram_addr = hold ? req_head.addr[lsu_pkg::RAM_AW+1:2] :
	                         cur_req.addr[lsu_pkg::RAM_AW+1:2];

	lsu_ctrl lsu_ctrl_i (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.req_valid_i(req_avail),
		.req_pop_o  (req_pop),
		.rsp_ready_i(rsp_room),
		.rsp_push_o (rsp_push),
		.store_i    (store),
		.exc_code_i (rsp_new.exc_code),
		.ram_ce_o   (ram_ce),
		.ram_we_o   (ram_we),
		.hold_o     (hold)
	);

	mem_align mem_align_i (
		.req_i      (cur_req),
		.rdata_i    (ram_rdata),
		.rsp_o      (rsp_new),
		.store_o    (store),
		.mem_sel_o  (ram_sel),
		.mem_wdata_o(ram_wdata)
	);

	data_ram data_ram_i (
		.clk    (clk),
		.ce_i   (ram_ce),
		.we_i   (ram_we),
		.sel_i  (ram_sel),
		.addr_i (ram_addr),
		.wdata_i(ram_wdata),
		.rdata_o(ram_rdata)
	);

	lsu_fifo #(.payload_t(lsu_pkg::lsu_rsp_t)) rsp_fifo_i (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.push_valid_i(rsp_push),
		.push_data_i (rsp_new),
		.push_ready_o(rsp_room),
		.pop_valid_o (rsp_valid_o),
		.pop_data_o  (rsp_out),
		.pop_ready_i (rsp_ready_i)
	);

	assign rsp_wd_o       = rsp_out.wd;
	assign rsp_wreg_o     = rsp_out.wreg;
	assign rsp_wdata_o    = rsp_out.wdata;
	assign rsp_exc_code_o = rsp_out.exc_code;
	assign rsp_epc_o      = rsp_out.epc;
	assign rsp_badvaddr_o = rsp_out.badvaddr;

endmodule

// ==== hdl/mem_align.sv ====
`timescale 1ns/1ps

module mem_align (
	input  lsu_pkg::lsu_req_t req_i,
	input  logic [31:0]       rdata_i,
	output lsu_pkg::lsu_rsp_t rsp_o,
	output logic              store_o,
	output logic [3:0]        mem_sel_o,
	output logic [31:0]       mem_wdata_o
);

	logic [1:0]         off;
	logic [7:0]         lane_byte;
	logic [15:0]        lane_half;
	logic               sext;
	logic               is_load;
	logic [31:0]        load_data;
	lsu_pkg::exc_code_t exc;
	logic               fault;

	// Little-endian lanes, byte 0 in bits 7:0
	assign off       = req_i.addr[1:0];
	assign lane_byte = rdata_i[{off, 3'b000} +: 8];
	assign lane_half = rdata_i[{off[1], 4'b0000} +: 16];
	assign sext      = (req_i.aluop == lsu_pkg::OP_LB) || (req_i.aluop == lsu_pkg::OP_LH);

	//////////////////////////////////////////////////////////////////////
	// Decode, extend and merge
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		is_load     = 1'b0;
		store_o     = 1'b0;
		exc         = lsu_pkg::EC_NONE;
		load_data   = 32'h0;
		mem_sel_o   = 4'b0000;
		// Unselected lanes keep the word just read
		mem_wdata_o = rdata_i;
		case (req_i.aluop)
			lsu_pkg::OP_LB, lsu_pkg::OP_LBU: begin
				is_load   = 1'b1;
				mem_sel_o = 4'b0001 << off;
				load_data = {{24{sext & lane_byte[7]}}, lane_byte};
			end
			lsu_pkg::OP_LH, lsu_pkg::OP_LHU: begin
				is_load = 1'b1;
				if (off[0]) begin
					exc = lsu_pkg::EC_ADEL;
				end else begin
					mem_sel_o = off[1] ? 4'b1100 : 4'b0011;
					load_data = {{16{sext & lane_half[15]}}, lane_half};
				end
			end
			lsu_pkg::OP_LW: begin
				is_load = 1'b1;
				if (off != 2'b00) begin
					exc = lsu_pkg::EC_ADEL;
				end else begin
					mem_sel_o = 4'b1111;
					load_data = rdata_i;
				end
			end
			lsu_pkg::OP_SB: begin
				store_o   = 1'b1;
				mem_sel_o = 4'b0001 << off;
				mem_wdata_o[{off, 3'b000} +: 8] = req_i.reg2[7:0];
			end
			lsu_pkg::OP_SH: begin
				store_o = 1'b1;
				if (off[0]) begin
					exc = lsu_pkg::EC_ADES;
				end else begin
					mem_sel_o = off[1] ? 4'b1100 : 4'b0011;
					mem_wdata_o[{off[1], 4'b0000} +: 16] = req_i.reg2[15:0];
				end
			end
			lsu_pkg::OP_SW: begin
				store_o = 1'b1;
				if (off != 2'b00) begin
					exc = lsu_pkg::EC_ADES;
				end else begin
					mem_sel_o   = 4'b1111;
					mem_wdata_o = req_i.reg2;
				end
			end
			default: begin
				// Anything else is a NOP
				mem_sel_o = 4'b0000;
			end
		endcase
	end

	assign fault = (exc != lsu_pkg::EC_NONE);

	assign rsp_o.wd       = req_i.wd;
	assign rsp_o.wreg     = is_load && !fault;
	assign rsp_o.wdata    = fault ? 32'h0 : load_data;
	assign rsp_o.exc_code = exc;
	assign rsp_o.epc      = fault ? req_i.epc : 32'h0;
	assign rsp_o.badvaddr = fault ? req_i.addr : 32'h0;

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the load/store unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module lsu_tb \
	-Mdir obj_dir -o lsu_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/lsu_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "TEST OK" sim.log; then
	exit 0
fi
echo "Pass message not found in sim.log"
exit 1
